// File: fetch_unit.f
design/imem_pkg.sv
design/predict_pkg.sv
design/fetch_control.sv
design/pc_select.sv
design/btac.sv
design/fetch_unit.sv
verification/imem_responder.sv
verification/fetch_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module fetch_unit_tb -f fetch_unit.f
if [ $? -ne 0 ]; then
  echo "build error"
  exit 1
fi

out=$(./obj_dir/Vfetch_unit_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if echo "$out" | grep -q "^all tests passed$"; then
  exit 0
fi
exit 1

// File: verification/fetch_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit_tb
  import imem_pkg::*;
  import predict_pkg::*;
;

  logic          clock;
  logic          reset;
  csr_redirect_t csr;
  resolve_t      resolve;
  fence_t        fence;
  logic          halt;
  logic          clear;
  imem_req_t     imem_req;
  imem_rsp_t     imem_rsp;
  fetch_out_t    fetch_out;
  logic          overlap;

  addr_t       exp_pc;       // next pc decode should see
  logic [15:0] m_valid;      // cache mirror
  addr_t       m_pc [16];
  addr_t       m_target [16];
  addr_t       last_pc;
  logic        last_taken;
  logic        spec_pend;    // redirect applied, its fetch not sent yet
  logic        fence_pend;
  int          errors;
  int          deliveries;
  int          req_count = 0;
  int          tests_run;
  int          tests_ok;

  fetch_unit #(.BTAC_ENTRIES(16)) fetch_unit_i (
    .clock(clock), .reset(reset), .csr(csr), .resolve(resolve), .fence(fence),
    .halt(halt), .clear(clear), .imem_req(imem_req), .imem_rsp(imem_rsp),
    .fetch_out(fetch_out)
  );

  imem_responder imem (
    .clock(clock), .reset(reset), .req(imem_req), .rsp(imem_rsp), .overlap(overlap)
  );

  always #10 clock = ~clock;

  // request strobes against the redirects applied by the stimulus
  always @(posedge clock) begin
    if (reset && imem_req.valid) begin
      req_count <= req_count + 1;
      assert (imem_req.spec == spec_pend && imem_req.fence == fence_pend) else begin
        $display("Fail %0t: request spec %b fence %b, expected %b %b", $time,
                 imem_req.spec, imem_req.fence, spec_pend, fence_pend);
        errors++;
      end
      spec_pend  = 1'b0;
      fence_pend = 1'b0;
    end
  end

  // ##########################################################
  // reference model
  // ##########################################################
  function automatic int entry_of(addr_t a);
    return int'(a[6:3]);  // 16 entries of 8-byte pairs
  endfunction

  function automatic logic mirror_hit(addr_t a);
    int e;
    e = entry_of(a);
    return m_valid[e] && (m_pc[e][31:3] == a[31:3]);
  endfunction

  function automatic void train_mirror(resolve_t r);
    int e;
    e = entry_of(r.pc);
    if (r.taken) begin
      m_valid[e]  = 1'b1;
      m_pc[e]     = r.pc;
      m_target[e] = r.target;
    end else if (mirror_hit(r.pc)) begin
      m_valid[e] = 1'b0;
    end
  endfunction

  function automatic addr_t rand_addr(logic [3:0] region);
    logic [31:0] r;
    r = $urandom;
    return {region, r[27:3], 3'b000};
  endfunction

  function automatic logic random_bit();
    return ($urandom & 32'd1) != 32'd0;
  endfunction

  task automatic check_output();
    logic hit;
    int   e;
    if (fetch_out.valid) begin
      e   = entry_of(exp_pc);
      hit = mirror_hit(exp_pc);
      assert (fetch_out.pc == exp_pc) else begin
        $display("Fail %0t: pc %h, expected %h", $time, fetch_out.pc, exp_pc);
        errors++;
      end
      assert (fetch_out.instr == {~exp_pc, exp_pc}) else begin
        $display("Fail %0t: instr %h at pc %h", $time, fetch_out.instr, fetch_out.pc);
        errors++;
      end
      assert (fetch_out.taken == hit) else begin
        $display("Fail %0t: taken %b at pc %h", $time, fetch_out.taken, fetch_out.pc);
        errors++;
      end
      if (hit) begin
        assert (fetch_out.taddr == m_target[e] && fetch_out.tpc == exp_pc) else begin
          $display("Fail %0t: tag taddr %h tpc %h, expected %h %h", $time,
                   fetch_out.taddr, fetch_out.tpc, m_target[e], exp_pc);
          errors++;
        end
      end
      last_pc    = fetch_out.pc;
      last_taken = fetch_out.taken;
      exp_pc     = hit ? m_target[e] : exp_pc + 32'd8;
      deliveries++;
    end
  endtask

  task automatic next_cycle();
    @(negedge clock);
    check_output();
  endtask

  task automatic idle_cycles(int n);
    repeat (n) next_cycle();
  endtask

  task automatic wait_delivery(int limit);
    int start;
    int n;
    start = deliveries;
    for (n = 0; n < limit && deliveries == start; n++) begin
      next_cycle();
    end
    if (deliveries == start) begin
      $display("timeout: no fetch output within %0d cycles at %0t", limit, $time);
      errors++;
    end
  endtask

  task automatic finish_test(string name, int err_before);
    tests_run++;
    if (errors == err_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: not ok, %0d errors", name, errors - err_before);
    end
  endtask

  // ##########################################################
  // stimulus
  // ##########################################################
  initial begin
    int    e0;
    int    d0;
    int    q0;
    int    i;
    int    sel;
    logic  miss;
    logic  saw_p;
    addr_t p;
    addr_t t;
    void'($urandom(32'h258f7229));
    clock   = 1'b0;
    reset   = 1'b0;
    csr     = '0;
    resolve = '0;
    fence   = '0;
    halt    = 1'b0;
    clear   = 1'b0;
    exp_pc  = '0;
    m_valid = '0;
    errors  = 0;
    deliveries = 0;
    tests_run  = 0;
    tests_ok   = 0;
    last_pc    = '0;
    last_taken = 1'b0;
    spec_pend  = 1'b0;
    fence_pend = 1'b0;
    repeat (8) @(negedge clock);
    reset = 1'b1;

    // sequential fetch from 0
    e0 = errors;
    next_cycle();
    assert (req_count == 1) else begin
      $display("Fail %0t: %0d requests in first cycle after reset", $time, req_count);
      errors++;
    end
    for (i = 0; i < 12; i++) wait_delivery(20);
    finish_test("sequential fetch", e0);

    // trap, mret and fence together
    e0 = errors;
    for (i = 0; i < 10; i++) begin
      idle_cycles($urandom_range(3, 0));
      sel          = $urandom_range(7, 1);
      csr.trap     = sel[0];
      csr.mret     = sel[1];
      fence.strobe = sel[2];
      csr.mtvec    = rand_addr(4'h4);
      csr.mepc     = rand_addr(4'h4);
      fence.npc    = rand_addr(4'h4);
      if (csr.trap) exp_pc = csr.mtvec;
      else if (csr.mret) exp_pc = csr.mepc;
      else exp_pc = fence.npc;
      spec_pend  = 1'b1;
      fence_pend = (sel == 4);  // fence wins only on its own
      next_cycle();
      csr   = '0;
      fence = '0;
      wait_delivery(20);
    end
    finish_test("redirect priority", e0);

    // train a taken branch two pairs ahead while halted
    e0 = errors;
    halt = 1'b1;
    idle_cycles(12);
    p = exp_pc + 32'd16;
    t = rand_addr(4'h6);
    resolve = '{update: 1'b1, pc: p, npc: p + 32'd8, target: t, is_branch: 1'b1,
                taken: 1'b1, pred_taken: 1'b1, pred_taddr: t};
    train_mirror(resolve);
    next_cycle();
    resolve = '0;
    next_cycle();
    halt  = 1'b0;
    saw_p = 1'b0;
    for (i = 0; i < 6 && !(last_pc == t && saw_p); i++) begin
      wait_delivery(20);
      if (last_pc == p) saw_p = last_taken;
    end
    assert (saw_p && last_pc == t) else begin
      $display("Fail %0t: branch at %h to %h not followed", $time, p, t);
      errors++;
    end
    finish_test("prediction", e0);

    // resolves that agree or disagree with their prediction
    e0 = errors;
    for (i = 0; i < 12; i++) begin
      idle_cycles($urandom_range(3, 0));
      resolve.update     = 1'b1;
      resolve.is_branch  = random_bit();
      resolve.pc         = rand_addr(4'h8);  // never fetched
      resolve.npc        = rand_addr(4'h5);
      resolve.target     = rand_addr(4'h5);
      resolve.pred_taken = random_bit();
      resolve.taken      = resolve.pred_taken;
      resolve.pred_taddr = resolve.target;
      sel                = $urandom_range(2, 0);
      if (sel == 1) begin
        resolve.taken = !resolve.pred_taken;  // wrong direction
      end else if (sel == 2) begin
        resolve.taken      = 1'b1;
        resolve.pred_taken = 1'b1;
        resolve.pred_taddr = resolve.target + 32'd8;  // taken to another target
      end
      miss = (sel != 0);
      if (resolve.is_branch) train_mirror(resolve);
      if (miss) begin
        exp_pc    = resolve.taken ? resolve.target : resolve.npc;
        spec_pend = 1'b1;
      end
      next_cycle();
      resolve = '0;
      wait_delivery(20);
    end
    finish_test("misprediction", e0);

    // halt, then clear from idle
    e0 = errors;
    d0 = deliveries;
    q0 = req_count;
    halt = 1'b1;
    idle_cycles(28);
    assert (deliveries - d0 == 1 && req_count == q0) else begin
      $display("Fail %0t: halted fetch gave %0d outputs and %0d requests", $time,
               deliveries - d0, req_count - q0);
      errors++;
    end
    d0    = deliveries;
    halt  = 1'b0;
    clear = 1'b1;
    idle_cycles(16);
    assert (deliveries == d0 && req_count == q0) else begin
      $display("Fail %0t: request left idle while clear was high", $time);
      errors++;
    end
    clear = 1'b0;
    for (i = 0; i < 4; i++) wait_delivery(20);
    finish_test("halt and clear", e0);

    assert (!overlap) else begin
      $display("memory saw a second request while one was outstanding");
      errors++;
    end
    $display("%0d tests run, %0d ok, %0d errors", tests_run, tests_ok, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/imem_responder.sv
`timescale 1ns/10ps
`default_nettype none

module imem_responder
  import imem_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  imem_req_t req,
  output imem_rsp_t rsp,
  output logic      overlap
);

  logic  took_q      = 1'b0;  // request issued at the last rising edge
  addr_t took_addr_q = '0;
  logic  pending;
  addr_t pend_addr;
  int    left;

  // pair for an address: the address, then its inverse in the upper word
  function automatic instr_pair_t pair_at(addr_t a);
    return {~a, a};
  endfunction

  always @(posedge clock) begin
    took_q      <= reset && req.valid;
    took_addr_q <= req.addr;
  end

  initial begin
    rsp       = '0;
    overlap   = 1'b0;
    pending   = 1'b0;
    pend_addr = '0;
    left      = 0;
    forever begin
      @(negedge clock);
      rsp.ready = 1'b0;
      if (!reset) begin
        pending = 1'b0;
      end else begin
        if (took_q) begin
          overlap   = overlap | pending;  // only one may be outstanding
          pending   = 1'b1;
          pend_addr = took_addr_q;
          left      = $urandom_range(4, 1);
        end
        if (pending) begin
          left = left - 1;
          if (left == 0) begin
            rsp.ready = 1'b1;
            rsp.rdata = pair_at(pend_addr);
            pending   = 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
  import imem_pkg::*;
  import predict_pkg::*;
#(
  parameter int BTAC_ENTRIES = 16
)
(
  input  logic          clock,
  input  logic          reset,
  input  csr_redirect_t csr,
  input  resolve_t      resolve,
  input  fence_t        fence,
  input  logic          halt,
  input  logic          clear,
  output imem_req_t     imem_req,
  input  imem_rsp_t     imem_rsp,
  output fetch_out_t    fetch_out
);

  logic     req_valid;
  logic     req_fence;
  logic     req_spec;
  addr_t    req_addr;
  logic     stall;
  logic     accept;
  logic     redirect;
  logic     fence_redirect;
  predict_t pred;
  miss_t    miss;

  assign imem_req = '{valid: req_valid, fence: req_fence, spec: req_spec,
                      addr: req_addr};

  fetch_control fetch_control_i (
    .clock          (clock),
    .reset          (reset),
    .halt           (halt),
    .clear          (clear),
    .rsp_ready      (imem_rsp.ready),
    .redirect       (redirect),
    .fence_redirect (fence_redirect),
    .req_valid      (req_valid),
    .req_fence      (req_fence),
    .req_spec       (req_spec),
    .stall          (stall),
    .accept         (accept)
  );

  pc_select pc_select_i (
    .clock          (clock),
    .reset          (reset),
    .csr            (csr),
    .miss           (miss),
    .fence          (fence),
    .pred           (pred),
    .stall          (stall),
    .accept         (accept),
    .rsp            (imem_rsp),
    .pc             (req_addr),
    .redirect       (redirect),
    .fence_redirect (fence_redirect),
    .out            (fetch_out)
  );

  btac #(
    .BTAC_ENTRIES (BTAC_ENTRIES)
  ) btac_i (
    .clock     (clock),
    .reset     (reset),
    .lookup_pc (req_addr),
    .resolve   (resolve),
    .pred      (pred),
    .miss      (miss)
  );

endmodule

`default_nettype wire

// File: design/btac.sv
`timescale 1ns/10ps
`default_nettype none

module btac
  import imem_pkg::*;
  import predict_pkg::*;
#(
  parameter int BTAC_ENTRIES = 16
)
(
  input  logic     clock,
  input  logic     reset,
  input  addr_t    lookup_pc,
  input  resolve_t resolve,
  output predict_t pred,
  output miss_t    miss
);

  localparam int ADDR_BITS   = $bits(addr_t);
  localparam int OFFSET_BITS = 3;  // one entry per 8-byte pair
  localparam int INDEX_BITS  = $clog2(BTAC_ENTRIES);
  localparam int TAG_BITS    = ADDR_BITS - OFFSET_BITS - INDEX_BITS;

  typedef logic [INDEX_BITS-1:0] btac_index_t;
  typedef logic [TAG_BITS-1:0]   btac_tag_t;

  logic [BTAC_ENTRIES-1:0] valid_q;
  btac_tag_t               tag_q    [BTAC_ENTRIES];
  addr_t                   target_q [BTAC_ENTRIES];

  btac_index_t get_index;
  btac_tag_t   get_tag;
  btac_index_t upd_index;
  btac_tag_t   upd_tag;
  logic        upd_hit;
  logic        train;
  logic        mispredict;

  // ##########################################################
  // lookup
  // ##########################################################
  assign get_index = lookup_pc[OFFSET_BITS +: INDEX_BITS];
  assign get_tag   = lookup_pc[ADDR_BITS-1 -: TAG_BITS];

  assign pred = '{
    hit:    valid_q[get_index] && (tag_q[get_index] == get_tag),
    pc:     lookup_pc,
    target: target_q[get_index]
  };

  // ##########################################################
  // training from resolved branches
  // ##########################################################
  assign upd_index = resolve.pc[OFFSET_BITS +: INDEX_BITS];
  assign upd_tag   = resolve.pc[ADDR_BITS-1 -: TAG_BITS];
  assign upd_hit   = valid_q[upd_index] && (tag_q[upd_index] == upd_tag);
  assign train     = resolve.update && resolve.is_branch;

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= '0;
    end else if (train) begin
      if (resolve.taken) begin
        valid_q[upd_index] <= 1'b1;
      end else if (upd_hit) begin
        valid_q[upd_index] <= 1'b0;  // only drop our own entry
      end
    end
  end

  always_ff @(posedge clock) begin
    if (train && resolve.taken) begin
      tag_q[upd_index]    <= upd_tag;
      target_q[upd_index] <= resolve.target;
    end
  end

  // direction wrong, or taken to another target
  assign mispredict = resolve.update &&
                      ((resolve.taken != resolve.pred_taken) ||
                       (resolve.taken && (resolve.target != resolve.pred_taddr)));

  assign miss = '{
    strobe: mispredict,
    addr:   resolve.taken ? resolve.target : resolve.npc
  };

endmodule

`default_nettype wire

// File: design/pc_select.sv
`timescale 1ns/10ps
`default_nettype none

module pc_select
  import imem_pkg::*;
  import predict_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  csr_redirect_t csr,
  input  miss_t         miss,
  input  fence_t        fence,
  input  predict_t      pred,
  input  logic          stall,
  input  logic          accept,
  input  imem_rsp_t     rsp,
  output addr_t         pc,
  output logic          redirect,
  output logic          fence_redirect,
  output fetch_out_t    out
);

  addr_t       pc_q;         // next pair to fetch
  addr_t       issue_pc;
  logic        use_pred;

  addr_t       req_pc_q;     // outstanding request
  logic        req_taken_q;
  addr_t       req_taddr_q;
  addr_t       req_tpc_q;

  logic        out_valid_q;
  addr_t       out_pc_q;
  instr_pair_t out_instr_q;
  logic        out_taken_q;
  addr_t       out_taddr_q;
  addr_t       out_tpc_q;

  // ##########################################################
  // next pc
  // ##########################################################
  always_comb begin
    redirect       = 1'b1;
    fence_redirect = 1'b0;
    if (csr.trap) begin
      issue_pc = csr.mtvec;
    end else if (csr.mret) begin
      issue_pc = csr.mepc;
    end else if (miss.strobe) begin
      issue_pc = miss.addr;
    end else if (fence.strobe) begin
      issue_pc       = fence.npc;
      fence_redirect = 1'b1;
    end else begin
      issue_pc = pc_q;
      redirect = 1'b0;
    end
  end

  assign use_pred = pred.hit && !redirect;  // no prediction for a redirect target
  assign pc       = issue_pc;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc_q <= '0;
    end else if (!stall) begin
      pc_q <= use_pred ? pred.target : issue_pc + addr_t'(8);
    end else if (redirect) begin
      pc_q <= issue_pc;  // sent once the stale pair is gone
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      req_pc_q    <= issue_pc;
      req_taken_q <= use_pred;
      req_taddr_q <= use_pred ? pred.target : '0;
      req_tpc_q   <= use_pred ? pred.pc : '0;
    end
  end

  // register to decode
  always_ff @(posedge clock) begin
    if (!reset) begin
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      out_pc_q    <= req_pc_q;
      out_instr_q <= rsp.rdata;
      out_taken_q <= req_taken_q;
      out_taddr_q <= req_taddr_q;
      out_tpc_q   <= req_tpc_q;
    end
  end

  assign out = '{valid: out_valid_q, pc: out_pc_q, instr: out_instr_q,
                 taken: out_taken_q, taddr: out_taddr_q, tpc: out_tpc_q};

  a_pc_aligned: assert property (
    @(posedge clock) disable iff (!reset)
    pc[2:0] == 3'b000
  );

  a_accept_ready: assert property (
    @(posedge clock) disable iff (!reset)
    accept |-> rsp.ready
  );

endmodule

`default_nettype wire

// File: design/fetch_control.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_control
  import predict_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic halt,
  input  logic clear,
  input  logic rsp_ready,
  input  logic redirect,
  input  logic fence_redirect,
  output logic req_valid,
  output logic req_fence,
  output logic req_spec,
  output logic stall,
  output logic accept
);

  fetch_state_t state_q;
  fetch_state_t state_d;
  logic         issue;         // request leaves this cycle
  logic         spec_pend_q;   // redirect taken, its fetch not sent yet
  logic         fence_pend_q;

  // ##########################################################
  // request and response decisions
  // ##########################################################
  always_comb begin
    state_d = state_q;
    issue   = 1'b0;
    accept  = 1'b0;
    case (state_q)
      fetch_idle: begin
        if (reset && !clear && !halt) begin
          issue   = 1'b1;
          state_d = fetch_busy;
        end
      end
      fetch_busy: begin
        if (rsp_ready) begin
          accept  = !redirect;  // redirect in this cycle drops the pair
          issue   = !halt;
          state_d = halt ? fetch_idle : fetch_busy;
        end else if (fence_redirect) begin
          state_d = fetch_inv;
        end else if (redirect) begin
          state_d = fetch_ctrl;
        end
      end
      fetch_ctrl, fetch_inv: begin
        if (rsp_ready) begin
          issue   = !halt;  // stale pair is discarded
          state_d = halt ? fetch_idle : fetch_busy;
        end else if (fence_redirect) begin
          state_d = fetch_inv;
        end
      end
      default: begin
        state_d = fetch_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q      <= fetch_idle;
      spec_pend_q  <= 1'b0;
      fence_pend_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (issue) begin
        spec_pend_q  <= 1'b0;
        fence_pend_q <= 1'b0;
      end else begin
        spec_pend_q  <= spec_pend_q | redirect;
        fence_pend_q <= fence_pend_q | fence_redirect;
      end
    end
  end

  assign req_valid = issue;
  assign req_spec  = issue && (redirect || spec_pend_q);
  assign req_fence = issue && (fence_redirect || fence_pend_q);
  assign stall     = !issue;  // pc holds unless a fetch goes out

  a_accept_busy: assert property (
    @(posedge clock) disable iff (!reset)
    accept |-> state_q == fetch_busy
  );

endmodule

`default_nettype wire

// File: design/predict_pkg.sv
`default_nettype none

package predict_pkg;

  import imem_pkg::*;

  typedef struct packed {
    logic  trap;
    logic  mret;
    addr_t mtvec;
    addr_t mepc;
  } csr_redirect_t;

  // one resolved control transfer from execute
  typedef struct packed {
    logic  update;
    addr_t pc;
    addr_t npc;         // fall-through address
    addr_t target;
    logic  is_branch;
    logic  taken;
    logic  pred_taken;  // tag that came with the pair
    addr_t pred_taddr;
  } resolve_t;

  typedef struct packed {
    logic  strobe;
    addr_t npc;
  } fence_t;

  typedef struct packed {
    logic  hit;
    addr_t pc;
    addr_t target;
  } predict_t;

  typedef struct packed {
    logic  strobe;
    addr_t addr;  // corrected fetch address
  } miss_t;

  typedef enum logic [1:0] {
    fetch_idle,
    fetch_busy,
    fetch_ctrl,  // waiting out a stale response
    fetch_inv    // same, fence pending
  } fetch_state_t;

endpackage

`default_nettype wire

// File: design/imem_pkg.sv
`default_nettype none

package imem_pkg;

  typedef logic [31:0] addr_t;        // byte address
  typedef logic [63:0] instr_pair_t;  // lower word is the instruction at addr

  typedef struct packed {
    logic  valid;
    logic  fence;  // invalidate before this fetch
    logic  spec;   // first fetch after a redirect
    addr_t addr;
  } imem_req_t;

  typedef struct packed {
    logic        ready;
    instr_pair_t rdata;
  } imem_rsp_t;

  // pair handed to decode, with the prediction that chose the next pc
  typedef struct packed {
    logic        valid;
    addr_t       pc;
    instr_pair_t instr;
    logic        taken;
    addr_t       taddr;
    addr_t       tpc;
  } fetch_out_t;

endpackage

`default_nettype wire
